// File: src.f
src/rename_pkg.sv
src/inst_queue.sv
src/free_list.sv
src/rat.sv
src/rename_dispatch.sv
src/rename_top.sv
dv/rename_tb.sv

// File: run.sh
#!/bin/sh
# Builds the rename testbench with Verilator and runs it into a log.
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --assert --timing -Wno-fatal --top-module rename_tb \
    -Mdir "$build_dir" -f src.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/Vrename_tb" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '>>> FAIL' "$log"; then
    exit 1
fi
if ! grep -q '>>> PASS' "$log"; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0

// File: dv/rename_tb.sv
`timescale 1ns/1ps

module rename_tb;
    import rename_pkg::*;

    localparam int timeout_cycles = 200;

    logic      clk;
    logic      rst;
    logic      fetch_valid;
    inst_t     fetch_inst;
    addr_t     fetch_pc;
    logic      iq_full;
    logic      rob_full;
    rob_idx_t  rob_num;
    logic [3:0] rs_full;
    logic      commit_valid;
    preg_t     commit_preg;
    logic      wb_valid;
    preg_t     wb_preg;
    logic      dispatch_valid;
    rs_class_t dispatch_class;
    inst_t     dispatch_inst;
    addr_t     dispatch_pc;
    order_t    dispatch_order;
    rob_idx_t  dispatch_rob_num;
    areg_t     dispatch_rd;
    preg_t     dispatch_pd;
    preg_t     dispatch_ps1;
    preg_t     dispatch_ps2;
    logic      dispatch_ps1_ready;
    logic      dispatch_ps2_ready;
    logic      dispatch_rd_we;

    int          errors = 0;
    int          tests = 0;
    logic [31:0] rng_state = 32'h8b87;
    addr_t       next_pc = 32'h1000;

    // The reference model advances on every rising edge.
    inst_t  pend_inst [$];
    addr_t  pend_pc [$];
    preg_t  free_q [$];
    preg_t  shadow_map [arch_regs];
    logic   shadow_rdy [arch_regs];
    order_t order_model;

    // What the head should look like during the coming cycle.
    int        exp_count;
    inst_t     exp_inst;
    addr_t     exp_pc;
    order_t    exp_order;
    rs_class_t exp_class;
    logic      exp_rd_we;
    preg_t     exp_pd;
    logic      exp_fl_empty;
    preg_t     exp_ps1;
    preg_t     exp_ps2;
    logic      exp_rdy1;
    logic      exp_rdy2;
    logic      exp_valid;

    rename_top i_rename_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic areg_t random_dest();
        return areg_t'(next_random() % 31 + 1);
    endfunction

    // All formats share the R-type field positions and immediates fill the rest.
    function automatic inst_t encode(input logic [6:0] f7, input areg_t rs2, input areg_t rs1,
                                     input logic [2:0] f3, input areg_t rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic rs_class_t classify(input inst_t inst);
        if (inst[6:0] == op_jal || inst[6:0] == op_jalr || inst[6:0] == op_br) return rs_br;
        if (inst[6:0] == op_reg && inst[31:25] == f7_muldiv) begin
            return (inst[14:12] < 3'd4) ? rs_mul : rs_div;
        end
        return rs_alu;
    endfunction

    function automatic logic writes_rd(input inst_t inst);
        logic [6:0] op;
        op = inst[6:0];
        if (inst[11:7] == 5'd0) return 1'b0;
        return op == op_lui || op == op_auipc || op == op_jal || op == op_jalr
            || op == op_load || op == op_imm || op == op_reg;
    endfunction

    always @(posedge clk) begin
        inst_t head;
        if (rst) begin
            pend_inst.delete();
            pend_pc.delete();
            free_q.delete();
            for (int i = 0; i < arch_regs; i++) begin
                shadow_map[i] = preg_t'(i);
                shadow_rdy[i] = 1'b1;
                free_q.push_back(preg_t'(arch_regs + i));
            end
            order_model = '0;
        end else begin
            if (wb_valid) begin
                for (int i = 0; i < arch_regs; i++) begin
                    if (shadow_map[i] == wb_preg) shadow_rdy[i] = 1'b1;
                end
            end
            // The new mapping goes in after writeback so that it stays busy.
            if (exp_valid) begin
                head = pend_inst[0];
                if (writes_rd(head) && free_q.size() != 0) begin
                    shadow_map[head[11:7]] = free_q.pop_front();
                    shadow_rdy[head[11:7]] = 1'b0;
                end
                void'(pend_inst.pop_front());
                void'(pend_pc.pop_front());
                order_model = order_model + 64'd1;
            end
            if (commit_valid) free_q.push_back(commit_preg);
            if (fetch_valid && exp_count != iq_depth) begin
                pend_inst.push_back(fetch_inst);
                pend_pc.push_back(fetch_pc);
            end
        end
        head = (pend_inst.size() != 0) ? pend_inst[0] : '0;
        exp_count    <= pend_inst.size();
        exp_inst     <= head;
        exp_pc       <= (pend_pc.size() != 0) ? pend_pc[0] : '0;
        exp_order    <= order_model;
        exp_class    <= classify(head);
        exp_rd_we    <= writes_rd(head);
        exp_pd       <= (free_q.size() != 0) ? free_q[0] : '0;
        exp_fl_empty <= (free_q.size() == 0);
        exp_ps1      <= shadow_map[head[19:15]];
        exp_ps2      <= shadow_map[head[24:20]];
        exp_rdy1     <= shadow_rdy[head[19:15]];
        exp_rdy2     <= shadow_rdy[head[24:20]];
    end

    assign exp_valid = (exp_count != 0) && !rob_full && !rs_full[exp_class]
                       && !(exp_rd_we && exp_fl_empty);

    task automatic report_mismatch(input string sig, input logic [63:0] got,
                                   input logic [63:0] want);
        $display("Mismatch %s: got %h expected %h at %0t", sig, got, want, $time);
        errors++;
    endtask

    a_valid: assert property (@(posedge clk) disable iff (rst) dispatch_valid == exp_valid)
        else report_mismatch("dispatch_valid", 64'($sampled(dispatch_valid)),
                             64'($sampled(exp_valid)));
    a_full: assert property (@(posedge clk) disable iff (rst)
        iq_full == (exp_count == iq_depth))
        else report_mismatch("iq_full", 64'($sampled(iq_full)),
                             64'($sampled(exp_count) == iq_depth));
    a_inst: assert property (@(posedge clk) disable iff (rst)
        dispatch_valid |-> dispatch_inst == exp_inst)
        else report_mismatch("dispatch_inst", 64'($sampled(dispatch_inst)),
                             64'($sampled(exp_inst)));
    a_pc: assert property (@(posedge clk) disable iff (rst)
        dispatch_valid |-> dispatch_pc == exp_pc)
        else report_mismatch("dispatch_pc", 64'($sampled(dispatch_pc)), 64'($sampled(exp_pc)));
    a_order: assert property (@(posedge clk) disable iff (rst)
        dispatch_valid |-> dispatch_order == exp_order)
        else report_mismatch("dispatch_order", $sampled(dispatch_order), $sampled(exp_order));
    a_rob: assert property (@(posedge clk) disable iff (rst)
        dispatch_valid |-> dispatch_rob_num == rob_num)
        else report_mismatch("dispatch_rob_num", 64'($sampled(dispatch_rob_num)),
                             64'($sampled(rob_num)));
    a_class: assert property (@(posedge clk) disable iff (rst)
        dispatch_valid |-> dispatch_class == exp_class)
        else report_mismatch("dispatch_class", 64'($sampled(dispatch_class)),
                             64'($sampled(exp_class)));
    a_rd: assert property (@(posedge clk) disable iff (rst)
        dispatch_valid |-> dispatch_rd == exp_inst[11:7])
        else report_mismatch("dispatch_rd", 64'($sampled(dispatch_rd)),
                             64'($sampled(exp_inst[11:7])));
    a_rd_we: assert property (@(posedge clk) disable iff (rst)
        dispatch_valid |-> dispatch_rd_we == exp_rd_we)
        else report_mismatch("dispatch_rd_we", 64'($sampled(dispatch_rd_we)),
                             64'($sampled(exp_rd_we)));
    a_pd: assert property (@(posedge clk) disable iff (rst)
        dispatch_valid && exp_rd_we |-> dispatch_pd == exp_pd)
        else report_mismatch("dispatch_pd", 64'($sampled(dispatch_pd)), 64'($sampled(exp_pd)));
    a_ps1: assert property (@(posedge clk) disable iff (rst)
        dispatch_valid |-> dispatch_ps1 == exp_ps1 && dispatch_ps1_ready == exp_rdy1)
        else report_mismatch("dispatch_ps1",
                             64'({$sampled(dispatch_ps1_ready), $sampled(dispatch_ps1)}),
                             64'({$sampled(exp_rdy1), $sampled(exp_ps1)}));
    a_ps2: assert property (@(posedge clk) disable iff (rst)
        dispatch_valid |-> dispatch_ps2 == exp_ps2 && dispatch_ps2_ready == exp_rdy2)
        else report_mismatch("dispatch_ps2",
                             64'({$sampled(dispatch_ps2_ready), $sampled(dispatch_ps2)}),
                             64'({$sampled(exp_rdy2), $sampled(exp_ps2)}));

    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b1;
        fetch_valid = 1'b0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
    endtask

    // Drives one instruction for a single edge once the queue has room.
    task automatic fetch(input inst_t inst);
        int waited;
        waited = 0;
        @(negedge clk);
        while (iq_full && waited < timeout_cycles) begin
            fetch_valid = 1'b0;
            waited++;
            @(negedge clk);
        end
        if (iq_full) begin
            $display("Timed out waiting for room in the instruction queue");
            errors++;
        end else begin
            fetch_valid = 1'b1;
            fetch_inst = inst;
            fetch_pc = next_pc;
            next_pc = next_pc + 32'd4;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(negedge clk);
        fetch_valid = 1'b0;
        while (exp_count != 0 && waited < timeout_cycles) begin
            rob_num = rob_idx_t'(next_random());
            waited++;
            @(negedge clk);
        end
        if (exp_count != 0) begin
            $display("Timed out waiting for the instruction queue to drain");
            errors++;
        end
    endtask

    task automatic wait_head_class(input rs_class_t c);
        int waited;
        waited = 0;
        @(negedge clk);
        fetch_valid = 1'b0;
        while (!(exp_count != 0 && exp_class == c) && waited < timeout_cycles) begin
            waited++;
            @(negedge clk);
        end
        if (!(exp_count != 0 && exp_class == c)) begin
            $display("Timed out waiting for a held head of class %0d", c);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("Test %s finished, %0d errors so far", name, errors);
    endtask

    initial begin
        int waited;
        rst = 1'b1;
        fetch_valid = 1'b0;
        fetch_inst = '0;
        fetch_pc = '0;
        rob_full = 1'b0;
        rob_num = '0;
        rs_full = '0;
        commit_valid = 1'b0;
        commit_preg = '0;
        wb_valid = 1'b0;
        wb_preg = '0;

        // A mix of writers, branches, stores and an x0 destination.
        apply_reset();
        repeat (4) @(negedge clk);
        for (int i = 0; i < 16; i++) begin
            case (i % 8)
                0: fetch(encode(f7_base, random_dest(), random_dest(), 3'd0,
                                random_dest(), op_reg));
                1: fetch(encode(f7_base, random_dest(), random_dest(), 3'd0, 5'd14, op_br));
                2: fetch(encode(f7_base, random_dest(), random_dest(), 3'd2, 5'd3, op_store));
                3: fetch(encode(f7_base, random_dest(), random_dest(), 3'd0,
                                random_dest(), op_lui));
                4: fetch(encode(f7_base, random_dest(), random_dest(), 3'd2,
                                random_dest(), op_load));
                5: fetch(encode(f7_base, random_dest(), random_dest(), 3'd0,
                                random_dest(), op_auipc));
                6: fetch(encode(f7_base, random_dest(), random_dest(), 3'd0,
                                random_dest(), op_imm));
                default: fetch(encode(f7_base, random_dest(), random_dest(), 3'd0, 5'd0, op_imm));
            endcase
        end
        drain();
        end_test("allocation_order");

        apply_reset();
        fetch(encode(f7_base, 5'd2, 5'd1, 3'd0, 5'd5, op_reg));
        fetch(encode(f7_base, 5'd5, 5'd5, 3'd0, 5'd6, op_reg));
        drain();
        wb_valid = 1'b1;
        wb_preg = shadow_map[5];
        @(negedge clk);
        wb_valid = 1'b0;
        fetch(encode(f7_base, 5'd3, 5'd5, 3'd0, 5'd7, op_reg));
        drain();
        end_test("renaming");

        // One pass per station runs with that station full.
        for (int c = 0; c < 4; c++) begin
            apply_reset();
            rs_full = 4'(1 << c);
            fetch(encode(f7_base, random_dest(), random_dest(), 3'd0, random_dest(), op_reg));
            fetch(encode(f7_muldiv, random_dest(), random_dest(), 3'd0, random_dest(), op_reg));
            fetch(encode(f7_muldiv, random_dest(), random_dest(), 3'd3, random_dest(), op_reg));
            fetch(encode(f7_muldiv, random_dest(), random_dest(), 3'd4, random_dest(), op_reg));
            fetch(encode(f7_muldiv, random_dest(), random_dest(), 3'd7, random_dest(), op_reg));
            fetch(encode(f7_base, random_dest(), random_dest(), 3'd0, 5'd8, op_br));
            fetch(encode(f7_base, random_dest(), random_dest(), 3'd0, random_dest(), op_jal));
            fetch(encode(f7_base, random_dest(), random_dest(), 3'd0, random_dest(), op_jalr));
            wait_head_class(rs_class_t'(c));
            repeat (4) @(negedge clk);
            rs_full = '0;
            drain();
        end
        end_test("classification");

        apply_reset();
        rob_full = 1'b1;
        for (int i = 0; i < iq_depth; i++) begin
            fetch(encode(f7_base, random_dest(), random_dest(), 3'd0, random_dest(), op_reg));
        end
        waited = 0;
        @(negedge clk);
        fetch_valid = 1'b0;
        while (!iq_full && waited < timeout_cycles) begin
            waited++;
            @(negedge clk);
        end
        if (!iq_full) begin
            $display("Timed out waiting for the instruction queue to fill");
            errors++;
        end
        // A push offered while full has to be dropped.
        fetch_valid = 1'b1;
        fetch_inst = encode(f7_base, 5'd1, 5'd1, 3'd0, 5'd9, op_reg);
        fetch_pc = 32'hdead_0000;
        @(negedge clk);
        fetch_valid = 1'b0;
        repeat (3) @(negedge clk);
        rob_full = 1'b0;
        drain();
        end_test("rob_stall");

        apply_reset();
        for (int i = 0; i < phys_regs - arch_regs; i++) begin
            fetch(encode(f7_base, random_dest(), random_dest(), 3'd0, random_dest(), op_reg));
        end
        fetch(encode(f7_base, 5'd4, 5'd3, 3'd0, 5'd10, op_reg));
        fetch(encode(f7_base, 5'd2, 5'd1, 3'd0, 5'd6, op_br));
        waited = 0;
        @(negedge clk);
        fetch_valid = 1'b0;
        while (!(exp_fl_empty && exp_count == 2) && waited < timeout_cycles) begin
            waited++;
            @(negedge clk);
        end
        if (!(exp_fl_empty && exp_count == 2)) begin
            $display("Timed out waiting for the free list to run dry");
            errors++;
        end
        repeat (4) @(negedge clk);
        commit_valid = 1'b1;
        commit_preg = 6'd40;
        @(negedge clk);
        commit_valid = 1'b0;
        drain();
        end_test("free_list_exhaustion");

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule : rename_tb

// File: src/rename_top.sv
`timescale 1ns/1ps

module rename_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  fetch_valid,
    input  rename_pkg::inst_t     fetch_inst,
    input  rename_pkg::addr_t     fetch_pc,
    output logic                  iq_full,
    input  logic                  rob_full,
    input  rename_pkg::rob_idx_t  rob_num,
    input  logic [3:0]            rs_full,
    input  logic                  commit_valid,
    input  rename_pkg::preg_t     commit_preg,
    input  logic                  wb_valid,
    input  rename_pkg::preg_t     wb_preg,
    output logic                  dispatch_valid,
    output rename_pkg::rs_class_t dispatch_class,
    output rename_pkg::inst_t     dispatch_inst,
    output rename_pkg::addr_t     dispatch_pc,
    output rename_pkg::order_t    dispatch_order,
    output rename_pkg::rob_idx_t  dispatch_rob_num,
    output rename_pkg::areg_t     dispatch_rd,
    output rename_pkg::preg_t     dispatch_pd,
    output rename_pkg::preg_t     dispatch_ps1,
    output rename_pkg::preg_t     dispatch_ps2,
    output logic                  dispatch_ps1_ready,
    output logic                  dispatch_ps2_ready,
    output logic                  dispatch_rd_we
);
    import rename_pkg::*;

    logic  iq_empty;
    logic  iq_pop;
    inst_t iq_inst;
    addr_t iq_pc;

    logic  fl_empty;
    logic  fl_pop;
    preg_t fl_head;

    areg_t rat_rs1;
    areg_t rat_rs2;
    preg_t rat_ps1;
    preg_t rat_ps2;
    logic  rat_rdy1;
    logic  rat_rdy2;
    logic  rat_we;
    areg_t rat_rd;
    preg_t rat_pd;

    inst_queue i_inst_queue (
        .clk       (clk),
        .rst       (rst),
        .push      (fetch_valid),
        .push_inst (fetch_inst),
        .push_pc   (fetch_pc),
        .full      (iq_full),
        .pop       (iq_pop),
        .empty     (iq_empty),
        .head_inst (iq_inst),
        .head_pc   (iq_pc)
    );

    // Committed instructions hand back the register their destination used to map to.
    free_list i_free_list (
        .clk       (clk),
        .rst       (rst),
        .pop       (fl_pop),
        .head      (fl_head),
        .empty     (fl_empty),
        .push      (commit_valid),
        .push_preg (commit_preg)
    );

    rat i_rat (
        .clk      (clk),
        .rst      (rst),
        .rs1      (rat_rs1),
        .rs2      (rat_rs2),
        .ps1      (rat_ps1),
        .ps2      (rat_ps2),
        .rdy1     (rat_rdy1),
        .rdy2     (rat_rdy2),
        .we       (rat_we),
        .rd       (rat_rd),
        .pd       (rat_pd),
        .wb_valid (wb_valid),
        .wb_preg  (wb_preg)
    );

    rename_dispatch i_rename_dispatch (
        .clk                (clk),
        .rst                (rst),
        .iq_empty           (iq_empty),
        .iq_inst            (iq_inst),
        .iq_pc              (iq_pc),
        .iq_pop             (iq_pop),
        .fl_empty           (fl_empty),
        .fl_head            (fl_head),
        .fl_pop             (fl_pop),
        .rat_rs1            (rat_rs1),
        .rat_rs2            (rat_rs2),
        .rat_ps1            (rat_ps1),
        .rat_ps2            (rat_ps2),
        .rat_rdy1           (rat_rdy1),
        .rat_rdy2           (rat_rdy2),
        .rat_we             (rat_we),
        .rat_rd             (rat_rd),
        .rat_pd             (rat_pd),
        .rob_full           (rob_full),
        .rob_num            (rob_num),
        .rs_full            (rs_full),
        .dispatch_valid     (dispatch_valid),
        .dispatch_class     (dispatch_class),
        .dispatch_inst      (dispatch_inst),
        .dispatch_pc        (dispatch_pc),
        .dispatch_order     (dispatch_order),
        .dispatch_rob_num   (dispatch_rob_num),
        .dispatch_rd        (dispatch_rd),
        .dispatch_pd        (dispatch_pd),
        .dispatch_ps1       (dispatch_ps1),
        .dispatch_ps2       (dispatch_ps2),
        .dispatch_ps1_ready (dispatch_ps1_ready),
        .dispatch_ps2_ready (dispatch_ps2_ready),
        .dispatch_rd_we     (dispatch_rd_we)
    );

endmodule : rename_top

// File: src/rename_dispatch.sv
`timescale 1ns/1ps

module rename_dispatch (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  iq_empty,
    input  rename_pkg::inst_t     iq_inst,
    input  rename_pkg::addr_t     iq_pc,
    output logic                  iq_pop,
    input  logic                  fl_empty,
    input  rename_pkg::preg_t     fl_head,
    output logic                  fl_pop,
    output rename_pkg::areg_t     rat_rs1,
    output rename_pkg::areg_t     rat_rs2,
    input  rename_pkg::preg_t     rat_ps1,
    input  rename_pkg::preg_t     rat_ps2,
    input  logic                  rat_rdy1,
    input  logic                  rat_rdy2,
    output logic                  rat_we,
    output rename_pkg::areg_t     rat_rd,
    output rename_pkg::preg_t     rat_pd,
    input  logic                  rob_full,
    input  rename_pkg::rob_idx_t  rob_num,
    input  logic [3:0]            rs_full,
    output logic                  dispatch_valid,
    output rename_pkg::rs_class_t dispatch_class,
    output rename_pkg::inst_t     dispatch_inst,
    output rename_pkg::addr_t     dispatch_pc,
    output rename_pkg::order_t    dispatch_order,
    output rename_pkg::rob_idx_t  dispatch_rob_num,
    output rename_pkg::areg_t     dispatch_rd,
    output rename_pkg::preg_t     dispatch_pd,
    output rename_pkg::preg_t     dispatch_ps1,
    output rename_pkg::preg_t     dispatch_ps2,
    output logic                  dispatch_ps1_ready,
    output logic                  dispatch_ps2_ready,
    output logic                  dispatch_rd_we
);
    import rename_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    areg_t      rd_field;
    logic       has_rd;
    logic       rd_we;
    rs_class_t  cls;
    order_t     order_q;

    assign opcode   = iq_inst[6:0];
    assign funct3   = iq_inst[14:12];
    assign funct7   = iq_inst[31:25];
    assign rd_field = iq_inst[11:7];

    // Pick the station. M-extension ops split on funct3[2].
    always_comb begin
        cls = rs_alu;
        case (opcode)
            op_jal, op_jalr, op_br: cls = rs_br;
            op_reg: begin
                case (funct7)
                    f7_muldiv:       cls = funct3[2] ? rs_div : rs_mul;
                    f7_base, f7_alt: cls = rs_alu;
                    default:         cls = rs_alu;
                endcase
            end
            default: cls = rs_alu;
        endcase
    end

    // Only instructions with a real destination consume a free register.
    always_comb begin
        case (opcode)
            op_lui, op_auipc, op_jal, op_jalr,
            op_load, op_imm, op_reg: has_rd = 1'b1;
            op_br, op_store:         has_rd = 1'b0;
            default:                 has_rd = 1'b0;
        endcase
    end

    assign rd_we = has_rd && (rd_field != '0);

    // Any single stall source holds the head where it is.
    assign dispatch_valid = !iq_empty && !rob_full && !rs_full[cls] && !(rd_we && fl_empty);

    assign iq_pop  = dispatch_valid;
    assign fl_pop  = dispatch_valid && rd_we;
    assign rat_we  = fl_pop;
    assign rat_rd  = rd_field;
    assign rat_pd  = fl_head;
    assign rat_rs1 = iq_inst[19:15];
    assign rat_rs2 = iq_inst[24:20];

    assign dispatch_class     = cls;
    assign dispatch_inst      = iq_inst;
    assign dispatch_pc        = iq_pc;
    assign dispatch_order     = order_q;
    assign dispatch_rob_num   = rob_num;
    assign dispatch_rd        = rd_field;
    assign dispatch_rd_we     = rd_we;
    assign dispatch_pd        = rd_we ? fl_head : '0;
    assign dispatch_ps1       = rat_ps1;
    assign dispatch_ps2       = rat_ps2;
    assign dispatch_ps1_ready = rat_rdy1;
    assign dispatch_ps2_ready = rat_rdy2;

    always_ff @(posedge clk) begin
        if (rst) begin
            order_q <= '0;
        end else if (dispatch_valid) begin
            order_q <= order_q + 64'd1;
        end
    end

    a_valid_has_head: assert property (@(posedge clk) disable iff (rst)
        dispatch_valid |-> !iq_empty)
        else $error("dispatch without a queued instruction");

    a_fl_pop_dispatch: assert property (@(posedge clk) disable iff (rst)
        fl_pop |-> dispatch_valid)
        else $error("free register taken without a dispatch");

endmodule : rename_dispatch

// File: src/rat.sv
`timescale 1ns/1ps

module rat (
    input  logic              clk,
    input  logic              rst,
    input  rename_pkg::areg_t rs1,
    input  rename_pkg::areg_t rs2,
    output rename_pkg::preg_t ps1,
    output rename_pkg::preg_t ps2,
    output logic              rdy1,
    output logic              rdy2,
    input  logic              we,
    input  rename_pkg::areg_t rd,
    input  rename_pkg::preg_t pd,
    input  logic              wb_valid,
    input  rename_pkg::preg_t wb_preg
);
    import rename_pkg::*;

    preg_t map [arch_regs];
    logic  rdy [arch_regs];

    // Reads see the table as it was before this edge's write.
    assign ps1  = map[rs1];
    assign ps2  = map[rs2];
    assign rdy1 = rdy[rs1];
    assign rdy2 = rdy[rs2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < arch_regs; i++) begin
                map[i] <= preg_t'(i);
                rdy[i] <= 1'b1;
            end
        end else begin
            // Several architectural registers may still point at the same
            // physical one, so every match is marked.
            if (wb_valid) begin
                for (int i = 0; i < arch_regs; i++) begin
                    if (map[i] == wb_preg) rdy[i] <= 1'b1;
                end
            end
            // A new mapping made on this edge wins over a writeback of it.
            if (we) begin
                map[rd] <= pd;
                rdy[rd] <= 1'b0;
            end
        end
    end

    // x0 stays mapped to p0 and always ready.
    a_no_x0_write: assert property (@(posedge clk) disable iff (rst) we |-> rd != '0)
        else $error("rat write to x0");

endmodule : rat

// File: src/free_list.sv
`timescale 1ns/1ps

module free_list (
    input  logic              clk,
    input  logic              rst,
    input  logic              pop,
    output rename_pkg::preg_t head,
    output logic              empty,
    input  logic              push,
    input  rename_pkg::preg_t push_preg
);
    import rename_pkg::*;

    // Only the registers above the architectural ones start out free,
    // and no more than that many can ever be outstanding.
    preg_t mem [phys_regs - arch_regs];

    logic [$clog2(phys_regs - arch_regs)-1:0] rd_ptr;
    logic [$clog2(phys_regs - arch_regs)-1:0] wr_ptr;
    preg_t count;

    logic do_pop;

    assign empty  = (count == '0);
    assign head   = mem[rd_ptr];
    assign do_pop = pop && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            // Entry i holds physical register 32 + i after reset.
            for (int i = 0; i < phys_regs - arch_regs; i++) begin
                mem[i] <= preg_t'(arch_regs + i);
            end
        end else if (push) begin
            mem[wr_ptr] <= push_preg;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            // The buffer starts full, so the write pointer sits on the read pointer.
            wr_ptr <= '0;
            count  <= preg_t'(phys_regs - arch_regs);
        end else begin
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            if (push) wr_ptr <= wr_ptr + 1'b1;
            count <= count + push - do_pop;
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        count <= preg_t'(phys_regs - arch_regs))
        else $error("free_list holds more registers than it can");

    // Dispatch is expected to check empty before taking a register.
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("free_list popped while empty");

endmodule : free_list

// File: src/inst_queue.sv
`timescale 1ns/1ps

module inst_queue (
    input  logic              clk,
    input  logic              rst,
    input  logic              push,
    input  rename_pkg::inst_t push_inst,
    input  rename_pkg::addr_t push_pc,
    output logic              full,
    input  logic              pop,
    output logic              empty,
    output rename_pkg::inst_t head_inst,
    output rename_pkg::addr_t head_pc
);
    import rename_pkg::*;

    inst_t inst_mem [iq_depth];
    addr_t pc_mem   [iq_depth];

    logic [$clog2(iq_depth)-1:0] wr_ptr;
    logic [$clog2(iq_depth)-1:0] rd_ptr;
    logic [$clog2(iq_depth+1)-1:0] count;

    logic do_push;
    logic do_pop;

    assign full    = (count == iq_depth);
    assign empty   = (count == 0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // The head is read straight from storage, so a new entry shows up one cycle after its push.
    assign head_inst = inst_mem[rd_ptr];
    assign head_pc   = pc_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            inst_mem[wr_ptr] <= push_inst;
            pc_mem[wr_ptr]   <= push_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + do_push - do_pop;
        end
    end

    // Rename must never take an instruction from an empty queue.
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("inst_queue popped while empty");

    a_count_bound: assert property (@(posedge clk) disable iff (rst) count <= iq_depth)
        else $error("inst_queue occupancy above depth");

endmodule : inst_queue

// File: src/rename_pkg.sv
package rename_pkg;

    // Register file sizes for RV32 with a 64-entry physical file.
    localparam int arch_regs = 32;
    localparam int phys_regs = 64;
    localparam int preg_bits = 6;

    // Depth of the queue between fetch and rename.
    localparam int iq_depth = 8;

    typedef logic [4:0]           areg_t;
    typedef logic [preg_bits-1:0] preg_t;
    typedef logic [31:0]          inst_t;
    typedef logic [31:0]          addr_t;
    typedef logic [63:0]          order_t;
    typedef logic [5:0]           rob_idx_t;

    // Major opcodes of the base ISA that rename has to tell apart.
    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;
    localparam logic [6:0] op_jal   = 7'b1101111;
    localparam logic [6:0] op_jalr  = 7'b1100111;
    localparam logic [6:0] op_br    = 7'b1100011;
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_reg   = 7'b0110011;

    // funct7 values seen with op_reg.
    localparam logic [6:0] f7_base   = 7'b0000000;
    localparam logic [6:0] f7_alt    = 7'b0100000;
    localparam logic [6:0] f7_muldiv = 7'b0000001;

    // Reservation station classes, also the bit index into rs_full.
    typedef enum logic [1:0] {
        rs_alu = 2'd0,
        rs_mul = 2'd1,
        rs_div = 2'd2,
        rs_br  = 2'd3
    } rs_class_t;

endpackage : rename_pkg
